// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    // machine word, used for pcs and register data
    typedef logic [31:0] word_t;

    // architectural register index, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // ra, marks calls (rd) and returns (rs1)
    localparam reg_idx_t link_reg = 5'd1;

    // trap handler entry
    localparam word_t excp_vector = 32'h0000_0100;

    // fixed instruction size, no compressed ISA
    localparam word_t instr_bytes = 32'd4;

endpackage

// ==== rtl/bp_pkg.sv ====
package bp_pkg;

    // 2-bit saturating counter
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_strong_nt = 2'd0;
    localparam ctr_t ctr_weak_nt   = 2'd1;
    localparam ctr_t ctr_weak_t    = 2'd2;
    localparam ctr_t ctr_strong_t  = 2'd3;

    // counters start just below the taken threshold
    localparam ctr_t ctr_reset = ctr_weak_nt;

    // 1024-entry table, indexed by pc[11:2]
    localparam int default_index_bits = 10;

    // return stack entries, power of two
    localparam int default_ras_depth = 128;

endpackage

// ==== rtl/bht_if.sv ====
`timescale 1ns/1ns

interface bht_if #(
    parameter int index_bits = 10
);

    logic [index_bits-1:0] rd_index;  // fetch pc word index
    bp_pkg::ctr_t          rd_ctr;    // counter at rd_index, same cycle
    logic                  wr_en;     // resolved branch from execute
    logic [index_bits-1:0] wr_index;
    logic                  wr_taken;  // step direction

    modport predictor (
        output rd_index, wr_en, wr_index, wr_taken,
        input  rd_ctr
    );

    modport tbl (
        input  rd_index, wr_en, wr_index, wr_taken,
        output rd_ctr
    );

endinterface

// ==== rtl/ras_if.sv ====
`timescale 1ns/1ns

interface ras_if #(
    parameter int ras_depth = 128
);

    logic                         push;
    logic                         pop;
    rv_pkg::word_t                push_addr;  // return address of a call
    rv_pkg::word_t                top_addr;   // entry at the pointer
    logic [$clog2(ras_depth)-1:0] ptr;        // stack pointer, owned by the stack

    modport predictor (
        output push, pop, push_addr,
        input  top_addr
    );

    modport stack (
        input  push, pop, push_addr,
        output top_addr, ptr
    );

endinterface

// ==== rtl/pattern_table.sv ====
`timescale 1ns/1ns

module pattern_table #(
    parameter int index_bits = 10
) (
    input logic clk,
    input logic rst,
    bht_if.tbl  bht
);

    localparam int entries = 1 << index_bits;

    bp_pkg::ctr_t ctrs [entries];
    bp_pkg::ctr_t cur_ctr;  // counter being updated
    bp_pkg::ctr_t new_ctr;

    // prediction read, no latency
    assign bht.rd_ctr = ctrs[bht.rd_index];

    assign cur_ctr = ctrs[bht.wr_index];

    // saturating step toward the resolved direction
    always_comb begin
        new_ctr = cur_ctr;
        if (bht.wr_taken) begin
            if (cur_ctr != bp_pkg::ctr_strong_t) begin
                new_ctr = cur_ctr + 2'd1;
            end
        end else begin
            if (cur_ctr != bp_pkg::ctr_strong_nt) begin
                new_ctr = cur_ctr - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                ctrs[i] <= bp_pkg::ctr_reset;  // all weakly not taken
            end
        end else if (bht.wr_en) begin
            ctrs[bht.wr_index] <= new_ctr;
        end
    end

endmodule

// ==== rtl/return_stack.sv ====
`timescale 1ns/1ns

module return_stack #(
    parameter int ras_depth = 128
) (
    input logic  clk,
    input logic  rst,
    ras_if.stack ras
);

    localparam int ptr_bits = $clog2(ras_depth);

    rv_pkg::word_t       slots [ras_depth];
    logic [ptr_bits-1:0] ptr_inc;  // slot after the pointer
    logic [ptr_bits-1:0] ptr_dec;

    // wraps modulo ras_depth so overflow drops the oldest entry
    assign ptr_inc = ras.ptr + 1'b1;
    assign ptr_dec = ras.ptr - 1'b1;

    assign ras.top_addr = slots[ras.ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            ras.ptr <= '0;
        end else if (ras.push) begin
            ras.ptr <= ptr_inc;
        end else if (ras.pop) begin
            ras.ptr <= ptr_dec;  // entry stays and only the pointer moves
        end
    end

    // return address storage
    always_ff @(posedge clk) begin
        if (ras.push) begin
            slots[ptr_inc] <= ras.push_addr;
        end
    end

endmodule

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/1ns

module branch_predictor #(
    parameter int index_bits = 10,
    parameter int ras_depth  = 128
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             branch,
    input  logic             predict,
    input  logic             ujtype,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    imm,
    input  rv_pkg::word_t    pc,
    input  logic             excp,
    input  rv_pkg::word_t    old_pc,
    input  rv_pkg::word_t    old_branch_pc,
    input  logic             old_predict,
    input  logic             old_actual,
    input  logic             old_branch,
    output rv_pkg::word_t    target_pc,
    output logic             predict_result,
    output logic             predict_fail,
    output rv_pkg::word_t    sepc,
    bht_if.predictor         bht,
    ras_if.predictor         ras
);

    logic          started;     // low for the first cycle after reset
    logic          is_jump;     // jal or jalr
    logic          is_call;
    logic          is_ret;
    logic          upd_ok;      // stack may change this cycle
    logic          pred_taken;
    rv_pkg::word_t pc_plus_4;
    rv_pkg::word_t pc_plus_imm;
    rv_pkg::word_t next_pc;     // before the exception override

    assign pc_plus_4   = pc + rv_pkg::instr_bytes;
    assign pc_plus_imm = pc + imm;

    assign is_jump = branch && !predict;
    assign is_call = rd == rv_pkg::link_reg;
    assign is_ret  = !is_call && rs1 == rv_pkg::link_reg;

    // execute resolved a branch against its prediction
    assign predict_fail = old_predict != old_actual;

    assign bht.rd_index = pc[index_bits+1:2];
    assign pred_taken   = bht.rd_ctr >= bp_pkg::ctr_weak_t;

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    always_comb begin
        if (rst || !started) begin
            predict_result = 1'b0;
            next_pc        = '0;
        end else if (predict_fail) begin
            predict_result = old_actual;  // redirect to the resolved path
            next_pc        = old_pc;
        end else begin
            case ({branch, predict})
                2'b10: begin
                    predict_result = 1'b1;
                    if (ujtype) begin
                        next_pc = pc_plus_imm;  // jal
                    end else if (rs1 == rv_pkg::link_reg) begin
                        next_pc = ras.top_addr;  // return
                    end else begin
                        next_pc = rs1_data + imm;  // indirect jalr
                    end
                end
                2'b11: begin
                    predict_result = pred_taken;
                    next_pc        = pred_taken ? pc_plus_imm : pc_plus_4;
                end
                default: begin
                    predict_result = 1'b0;  // sequential flow
                    next_pc        = pc_plus_4;
                end
            endcase
        end
    end

    assign target_pc = excp ? rv_pkg::excp_vector : next_pc;

    // counter update from the branch now in execute
    assign bht.wr_en    = old_branch && !stall;
    assign bht.wr_index = old_branch_pc[index_bits+1:2];
    assign bht.wr_taken = old_actual;

    // calls push the link address and returns pop it
    assign upd_ok        = !rst && started && !stall;
    assign ras.push      = upd_ok && is_jump && is_call;
    assign ras.pop       = upd_ok && is_jump && is_ret;
    assign ras.push_addr = pc_plus_4;

    always_ff @(posedge clk) begin
        if (rst) begin
            sepc <= '0;
        end else if (excp) begin
            sepc <= pc_plus_4;  // resume after the trapping instruction
        end
    end

endmodule

// ==== rtl/fetch_predictor_top.sv ====
`timescale 1ns/1ns

module fetch_predictor_top #(
    parameter int index_bits = bp_pkg::default_index_bits,
    parameter int ras_depth  = bp_pkg::default_ras_depth
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             branch,
    input  logic             predict,
    input  logic             ujtype,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    imm,
    input  rv_pkg::word_t    pc,
    input  logic             excp,
    input  rv_pkg::word_t    old_pc,
    input  rv_pkg::word_t    old_branch_pc,
    input  logic             old_predict,
    input  logic             old_actual,
    input  logic             old_branch,
    output rv_pkg::word_t    target_pc,
    output logic             predict_result,
    output logic             predict_fail,
    output rv_pkg::word_t    sepc
);

    bht_if #(.index_bits(index_bits)) bht_bus ();
    ras_if #(.ras_depth(ras_depth))   ras_bus ();

    branch_predictor #(
        .index_bits(index_bits),
        .ras_depth (ras_depth)
    ) u_predictor (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .branch        (branch),
        .predict       (predict),
        .ujtype        (ujtype),
        .rs1           (rs1),
        .rd            (rd),
        .rs1_data      (rs1_data),
        .imm           (imm),
        .pc            (pc),
        .excp          (excp),
        .old_pc        (old_pc),
        .old_branch_pc (old_branch_pc),
        .old_predict   (old_predict),
        .old_actual    (old_actual),
        .old_branch    (old_branch),
        .target_pc     (target_pc),
        .predict_result(predict_result),
        .predict_fail  (predict_fail),
        .sepc          (sepc),
        .bht           (bht_bus.predictor),
        .ras           (ras_bus.predictor)
    );

    pattern_table #(
        .index_bits(index_bits)
    ) u_table (
        .clk(clk),
        .rst(rst),
        .bht(bht_bus.tbl)
    );

    return_stack #(
        .ras_depth(ras_depth)
    ) u_stack (
        .clk(clk),
        .rst(rst),
        .ras(ras_bus.stack)
    );

endmodule

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen #(
    parameter int period     = 100,
    parameter int rst_cycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #10;
        rst = 1'b0;  // released with the other inputs
    end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;

    localparam int index_bits  = 4;
    localparam int ras_depth   = 8;
    localparam int test_cycles = 4 + 3 + 4 + (2 * ras_depth + 4) + 8 + 4 + 2 + 6 + 40 + 1;

    logic clk;
    logic rst;
    logic stall;
    logic branch;
    logic predict;
    logic ujtype;
    logic excp;
    logic old_predict;
    logic old_actual;
    logic old_branch;
    logic predict_result;
    logic predict_fail;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t rs1_data;
    rv_pkg::word_t imm;
    rv_pkg::word_t pc;
    rv_pkg::word_t old_pc;
    rv_pkg::word_t old_branch_pc;
    rv_pkg::word_t target_pc;
    rv_pkg::word_t sepc;

    // model state, advanced at each rising edge
    bp_pkg::ctr_t                 m_ctr [1 << index_bits];
    rv_pkg::word_t                m_stack [ras_depth];
    logic [$clog2(ras_depth)-1:0] m_ptr;
    logic                         m_started;
    rv_pkg::word_t                m_sepc;

    logic [31:0] seed = 32'h7e08;
    int word_errs = 0;
    int bit_errs  = 0;

    clk_gen u_clk (.clk(clk), .rst(rst));

    fetch_predictor_top #(
        .index_bits(index_bits),
        .ras_depth (ras_depth)
    ) uut (.*);

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // expected next fetch address and prediction for the current inputs
    function automatic rv_pkg::word_t predict_model(output logic exp_result);
        rv_pkg::word_t t;
        logic taken;
        taken = m_ctr[pc[index_bits+1:2]] > bp_pkg::ctr_reset;
        exp_result = 1'b0;
        t = pc + 32'd4;
        if (rst || !m_started) begin
            t = '0;
        end else if (old_predict != old_actual) begin
            exp_result = old_actual;  // correction from execute wins
            t = old_pc;
        end else if (branch && !predict) begin
            exp_result = 1'b1;
            if (ujtype) begin
                t = pc + imm;
            end else if (rs1 == rv_pkg::link_reg) begin
                t = m_stack[m_ptr];
            end else begin
                t = rs1_data + imm;
            end
        end else if (branch) begin
            exp_result = taken;
            t = taken ? pc + imm : pc + 32'd4;
        end
        if (excp) begin
            t = rv_pkg::excp_vector;
        end
        return t;
    endfunction

    task automatic update_model();
        logic [index_bits-1:0] idx;
        idx = old_branch_pc[index_bits+1:2];
        if (rst) begin
            foreach (m_ctr[i]) begin
                m_ctr[i] = bp_pkg::ctr_reset;
            end
            m_ptr = '0;
            m_started = 1'b0;
            m_sepc = '0;
        end else begin
            if (old_branch && !stall) begin
                if (old_actual && m_ctr[idx] != 2'd3) begin
                    m_ctr[idx]++;
                end else if (!old_actual && m_ctr[idx] != 2'd0) begin
                    m_ctr[idx]--;
                end
            end
            if (m_started && !stall && branch && !predict) begin
                if (rd == rv_pkg::link_reg) begin
                    m_ptr++;
                    m_stack[m_ptr] = pc + 32'd4;  // call
                end else if (rs1 == rv_pkg::link_reg) begin
                    m_ptr--;  // return
                end
            end
            if (excp) begin
                m_sepc = pc + 32'd4;
            end
            m_started = 1'b1;
        end
    endtask

    task automatic check_word(input string what, input rv_pkg::word_t got,
                              input rv_pkg::word_t expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            word_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, expected);
            bit_errs++;
        end
    endtask

    task automatic clear_inputs();
        stall = 1'b0;
        branch = 1'b0;
        predict = 1'b0;
        ujtype = 1'b0;
        excp = 1'b0;
        rs1 = '0;
        rd = '0;
        rs1_data = next_rand();
        imm = next_rand() & 32'h0000_0ffc;
        pc = next_rand() & 32'h0000_fffc;
        old_pc = next_rand() & 32'h0000_fffc;
        old_branch_pc = next_rand() & 32'h0000_fffc;
        old_predict = 1'b0;
        old_actual = 1'b0;
        old_branch = 1'b0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        update_model();
        #10;
        clear_inputs();
    endtask

    initial begin : compare
        rv_pkg::word_t exp_pc;
        logic exp_res;
        forever begin
            @(posedge clk);
            #90;  // outputs settled, next edge 10 ns away
            exp_pc = predict_model(exp_res);
            check_word("target_pc", target_pc, exp_pc);
            check_bit("predict_result", predict_result, exp_res);
            check_bit("predict_fail", predict_fail, old_predict != old_actual);
            check_word("sepc", sepc, m_sepc);
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        clear_inputs();
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            branch = 1'b1;  // calls across the reset window
            ujtype = 1'b1;
            rd = rv_pkg::link_reg;
            excp = (i == 1);
        end
        repeat (3) next_cycle();
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            branch = 1'b1;
            ujtype = (i < 2);  // jal, then indirect jalr
            rs1 = 5'd5;
        end
        // calls wrap the stack, returns unwind it
        for (int i = 0; i < 2 * ras_depth + 4; i++) begin
            next_cycle();
            branch = 1'b1;
            ujtype = (i < ras_depth + 2);
            rd = (i < ras_depth + 2) ? rv_pkg::link_reg : 5'd0;
            rs1 = (i < ras_depth + 2) ? 5'd0 : rv_pkg::link_reg;
        end
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            pc = 32'h0000_0040;
            branch = 1'b1;
            predict = 1'b1;
            old_branch = 1'b1;
            old_branch_pc = 32'h0000_0040;
            old_actual = (i < 4);  // saturate taken, then walk back
            old_predict = (i < 4);
        end
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            branch = 1'b1;
            predict = i[0];
            old_actual = i[1];
            old_predict = !i[1];
        end
        next_cycle();
        excp = 1'b1;
        next_cycle();
        // stalled outcomes and calls, then checked unstalled
        for (int i = 0; i < 6; i++) begin
            next_cycle();
            stall = (i < 4);
            branch = 1'b1;
            pc = 32'h0000_0040;
            predict = (i % 2 == 0);
            ujtype = (i % 2 == 1) && (i < 4);
            rd = (i % 2 == 1 && i < 4) ? rv_pkg::link_reg : 5'd0;
            rs1 = rv_pkg::link_reg;
            old_branch = (i < 4);
            old_branch_pc = 32'h0000_0040;
            old_actual = 1'b1;
            old_predict = 1'b1;
        end
        for (int i = 0; i < 40; i++) begin
            next_cycle();
            r = next_rand();
            stall = r[0];
            branch = r[1];
            predict = r[2];
            ujtype = r[3];
            rd = r[4] ? rv_pkg::link_reg : 5'd7;
            rs1 = r[5] ? rv_pkg::link_reg : 5'd9;
            old_branch = r[6];
            old_actual = r[7];
            old_predict = r[7] ^ (r[8] & r[9]);
            excp = r[10] & r[11] & r[12];
        end
        next_cycle();
        #85;
        $display("summary: %0d word errors, %0d bit errors", word_errs, bit_errs);
        if (word_errs + bit_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((test_cycles + 20) * 100);
        $display("timeout: stimulus did not complete within %0d cycles", test_cycles + 20);
        $display("test failed");
        $finish;
    end

endmodule

// ==== fetch_predictor_top.f ====
rtl/rv_pkg.sv
rtl/bp_pkg.sv
rtl/bht_if.sv
rtl/ras_if.sv
rtl/pattern_table.sv
rtl/return_stack.sv
rtl/branch_predictor.sv
rtl/fetch_predictor_top.sv
verif/clk_gen.sv
verif/tb_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_top -f fetch_predictor_top.f \
    -o tb_top_sim > build.log 2>&1 && ./obj_dir/tb_top_sim > sim.log 2>&1 \
    || { echo "build or simulation did not run, see build.log and sim.log"; exit 1; }
grep -q "test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
